// ==== compile.f ====
+incdir+include
rtl/scurve_pkg.sv
rtl/scurve_edge_sync.sv
rtl/scurve_delay_line.sv
rtl/scurve_counter.sv
rtl/scurve_single_input.sv
tests/scurve_tb.sv

// ==== rtl/scurve_counter.sv ====
`timescale 1ns/1ns

module scurve_counter
  import scurve_pkg::*;
(
  input  logic             clk_n,
  input  logic             reset_n,
  input  scurve_event_t    dly_evt,
  input  logic             trig_in_window,
  input  logic             test_start,
  input  scurve_cfg_t      cfg,
  output logic [CNT_W-1:0] cpt_pulse,
  output logic [CNT_W-1:0] cpt_trigger,
  output logic             cpt_done
);

  logic             start_q;
  logic             start_rise;
  logic             counting;
  logic             pulse_inc;
  logic             trig_inc;
  logic [CNT_W-1:0] pulse_next;
  logic [CNT_W-1:0] trig_next;
  logic             reach_max;

  assign start_rise = test_start & ~start_q;
  assign counting   = test_start & ~cpt_done & ~start_rise;  // first cycle only clears

  // mode decides what bumps the trigger count
  always_comb begin
    pulse_inc = counting & dly_evt.pulse;
    if (cfg.mode == MODE_TRIG_EFFI) begin
      trig_inc = counting & dly_evt.pulse & trig_in_window;
    end else begin
      trig_inc = counting & dly_evt.trigger;
    end
  end

  assign pulse_next = cpt_pulse + CNT_W'(1);
  assign trig_next  = cpt_trigger + CNT_W'(1);
  assign reach_max  = pulse_inc && (pulse_next == cfg.cpt_max);

  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      start_q <= 1'b0;
    end else begin
      start_q <= test_start;
    end
  end

  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      cpt_pulse   <= '0;
      cpt_trigger <= '0;
    end else if (start_rise) begin
      // new scan starts from zero
      cpt_pulse   <= '0;
      cpt_trigger <= '0;
    end else begin
      if (pulse_inc) begin
        cpt_pulse <= pulse_next;
      end
      if (trig_inc) begin
        cpt_trigger <= trig_next;
      end
    end
  end

  // done goes high together with the last pulse count
  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      cpt_done <= 1'b0;
    end else if (!test_start || start_rise) begin
      cpt_done <= 1'b0;
    end else if (reach_max) begin
      cpt_done <= 1'b1;
    end
  end

endmodule

// ==== rtl/scurve_delay_line.sv ====
`timescale 1ns/1ns

module scurve_delay_line
  import scurve_pkg::*;
(
  input  logic               clk_n,
  input  logic               reset_n,
  input  scurve_event_t      evt,
  input  logic [DELAY_W-1:0] trigger_delay,
  output scurve_event_t      dly_evt,
  output logic               trig_in_window
);

  // stored history, bit k holds the event from k cycles ago
  logic [DELAY_DEPTH-1:1] pulse_sr;
  logic [DELAY_DEPTH-1:1] trig_sr;

  // all entries including the live input as entry 0
  logic [DELAY_DEPTH-1:0] pulse_taps;
  logic [DELAY_DEPTH-1:0] trig_taps;
  logic [DELAY_DEPTH-1:0] win_mask;

  assign pulse_taps = {pulse_sr, evt.pulse};
  assign trig_taps  = {trig_sr, evt.trigger};

  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      pulse_sr <= '0;
      trig_sr  <= '0;
    end else begin
      pulse_sr <= pulse_taps[DELAY_DEPTH-2:0];
      trig_sr  <= trig_taps[DELAY_DEPTH-2:0];
    end
  end

  // window covers entries 0 .. trigger_delay
  always_comb begin
    for (int k = 0; k < DELAY_DEPTH; k++) begin
      win_mask[k] = (k <= int'(trigger_delay));
    end
  end

  // a trigger up to trigger_delay cycles after the injection
  // is still inside the window when the delayed pulse comes out
  assign trig_in_window = |(trig_taps & win_mask);

  assign dly_evt.pulse   = pulse_taps[trigger_delay];
  assign dly_evt.trigger = evt.trigger;  // count mode wants the live edge

endmodule

// ==== rtl/scurve_edge_sync.sv ====
`timescale 1ns/1ns

module scurve_edge_sync
  import scurve_pkg::*;
(
  input  logic          clk_n,
  input  logic          reset_n,
  input  logic          ext_pulse,  // async, rising edge = injection
  input  logic          trigger,    // async, active low
  output scurve_event_t evt
);

  logic [1:0] pulse_sync;  // [1] is the stable copy
  logic [1:0] trig_sync;
  logic       pulse_hist;
  logic       trig_hist;

  // injection path
  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      pulse_sync <= '0;
      pulse_hist <= 1'b0;
      evt.pulse  <= 1'b0;
    end else begin
      pulse_sync <= {pulse_sync[0], ext_pulse};
      pulse_hist <= pulse_sync[1];
      evt.pulse  <= pulse_sync[1] & ~pulse_hist;  // rising edge
    end
  end

  // discriminator path, idle level is high
  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      trig_sync   <= '1;
      trig_hist   <= 1'b1;  // no false edge when reset releases
      evt.trigger <= 1'b0;
    end else begin
      trig_sync   <= {trig_sync[0], trigger};
      trig_hist   <= trig_sync[1];
      evt.trigger <= ~trig_sync[1] & trig_hist;  // falling edge
    end
  end

endmodule

// ==== rtl/scurve_pkg.sv ====
package scurve_pkg;

  // counter and configuration widths
  localparam int CNT_W       = 16;
  localparam int DELAY_W     = 4;
  localparam int DELAY_DEPTH = 16;  // entries in the delay line, entry 0 is the live input

  // counting mode of the scan
  typedef enum logic {
    MODE_COUNT_EFFI = 1'b0,  // every trigger edge counts
    MODE_TRIG_EFFI  = 1'b1   // only injections that were hit count
  } scurve_mode_e;

  // single-cycle events after synchronization
  typedef struct packed {
    logic pulse;    // one injection
    logic trigger;  // one discriminator response
  } scurve_event_t;

  // scan configuration, held stable while test_start is high
  typedef struct packed {
    logic [CNT_W-1:0]   cpt_max;        // injections per scan
    logic [DELAY_W-1:0] trigger_delay;  // window length after an injection
    scurve_mode_e       mode;
  } scurve_cfg_t;

endpackage

// ==== rtl/scurve_single_input.sv ====
`timescale 1ns/1ns

module scurve_single_input
  import scurve_pkg::*;
(
  input  logic             clk_n,
  input  logic             reset_n,
  input  logic             ext_pulse,   // injection strobe, async
  input  logic             trigger,     // discriminator, async, active low
  input  logic             test_start,
  input  scurve_cfg_t      cfg,
  output logic [CNT_W-1:0] cpt_pulse,
  output logic [CNT_W-1:0] cpt_trigger,
  output logic             cpt_done
);

  scurve_event_t evt;
  scurve_event_t dly_evt;
  logic          trig_in_window;

  scurve_edge_sync u_edge_sync (
    .clk_n     (clk_n),
    .reset_n   (reset_n),
    .ext_pulse (ext_pulse),
    .trigger   (trigger),
    .evt       (evt)
  );

  // lines the injection up with the end of its trigger window
  scurve_delay_line u_delay_line (
    .clk_n          (clk_n),
    .reset_n        (reset_n),
    .evt            (evt),
    .trigger_delay  (cfg.trigger_delay),
    .dly_evt        (dly_evt),
    .trig_in_window (trig_in_window)
  );

  scurve_counter u_counter (
    .clk_n          (clk_n),
    .reset_n        (reset_n),
    .dly_evt        (dly_evt),
    .trig_in_window (trig_in_window),
    .test_start     (test_start),
    .cfg            (cfg),
    .cpt_pulse      (cpt_pulse),
    .cpt_trigger    (cpt_trigger),
    .cpt_done       (cpt_done)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the S-curve front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f compile.f \
  --top-module scurve_tb \
  -Mdir obj_dir \
  -o scurve_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/scurve_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" <<< "$output"; then
  exit 0
fi
echo "pass message not found"
exit 1

// ==== include/scurve_tb_model.svh ====
`ifndef SCURVE_TB_MODEL_SVH
`define SCURVE_TB_MODEL_SVH

// linear congruential generator, one step
function automatic int unsigned lcg_next(input int unsigned state);
  return state * 32'd1103515245 + 32'd12345;
endfunction

// map a generator state onto lo .. hi
function automatic int unsigned lcg_pick(input int unsigned state, input int unsigned lo,
                                         input int unsigned hi);
  return lo + ((state >> 16) % (hi - lo + 1));
endfunction

// reference model of one scan, cycles are sample cycles of the input edges
int unsigned pulse_cyc[$];
int unsigned trig_cyc[$];

function automatic void clear_model();
  pulse_cyc.delete();
  trig_cyc.delete();
endfunction

function automatic void add_pulse(input int unsigned c);
  pulse_cyc.push_back(c);
endfunction

function automatic void add_trigger(input int unsigned c);
  trig_cyc.push_back(c);
endfunction

// the scan stops at cpt_max, later injections are recorded but ignored
function automatic int unsigned expected_pulses(input int unsigned cpt_max);
  if (pulse_cyc.size() < cpt_max) begin
    return pulse_cyc.size();
  end
  return cpt_max;
endfunction

function automatic int unsigned expected_triggers(input scurve_mode_e mode,
                                                  input int unsigned delay,
                                                  input int unsigned cpt_max);
  int unsigned n;
  int unsigned hits;
  int unsigned last;
  bit          hit;
  n = expected_pulses(cpt_max);
  hits = 0;
  if (n == 0) begin
    return 0;
  end
  if (mode == MODE_TRIG_EFFI) begin
    for (int unsigned i = 0; i < n; i++) begin
      hit = 1'b0;
      foreach (trig_cyc[j]) begin
        if (trig_cyc[j] >= pulse_cyc[i] && trig_cyc[j] <= pulse_cyc[i] + delay) begin
          hit = 1'b1;
        end
      end
      if (hit) begin
        hits++;
      end
    end
  end else begin
    last = pulse_cyc[n-1] + delay;  // done falls on the last delayed pulse
    foreach (trig_cyc[j]) begin
      if (trig_cyc[j] <= last) begin
        hits++;
      end
    end
  end
  return hits;
endfunction

`endif

// ==== tests/scurve_tb.sv ====
`timescale 1ns/1ns

module scurve_tb
  import scurve_pkg::*;
();

  logic             clk_n;
  logic             reset_n;
  logic             ext_pulse;
  logic             trigger;
  logic             test_start;
  scurve_cfg_t      cfg;
  logic [CNT_W-1:0] cpt_pulse;
  logic [CNT_W-1:0] cpt_trigger;
  logic             cpt_done;

  int unsigned rng;           // generator state
  int unsigned cyc = 0;       // rising edges seen so far
  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned test_err_mark;
  int unsigned saved_pulse;   // expected counts of the last scan
  int unsigned saved_trig;

`include "scurve_tb_model.svh"

  scurve_single_input uut (
    .clk_n       (clk_n),
    .reset_n     (reset_n),
    .ext_pulse   (ext_pulse),
    .trigger     (trigger),
    .test_start  (test_start),
    .cfg         (cfg),
    .cpt_pulse   (cpt_pulse),
    .cpt_trigger (cpt_trigger),
    .cpt_done    (cpt_done)
  );

  initial begin
    clk_n = 1'b0;
    forever #10 clk_n = ~clk_n;
  end

  always @(posedge clk_n) cyc <= cyc + 1;

  function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
    rng = lcg_next(rng);
    return lcg_pick(rng, lo, hi);
  endfunction

  task automatic check_value(input string what, input int unsigned got,
                             input int unsigned exp);
    assert (got == exp) else begin
      $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic begin_test();
    test_err_mark = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err_mark) begin
      $display("test %0d, %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d, %s: %0d errors", tests_run, name, errors - test_err_mark);
    end
  endtask

  task automatic wait_done(input logic level, input int unsigned limit);
    int unsigned n;
    n = 0;
    @(negedge clk_n);
    while (cpt_done !== level && n < limit) begin
      @(negedge clk_n);
      n++;
    end
    assert (cpt_done === level) else begin
      report_timeout($sformatf("cpt_done did not go to %0b within %0d cycles", level, limit));
    end
  endtask

  // counts go back to zero right after a scan start
  task automatic wait_cleared(input int unsigned limit);
    int unsigned n;
    n = 0;
    @(negedge clk_n);
    while ((cpt_pulse != '0 || cpt_trigger != '0) && n < limit) begin
      @(negedge clk_n);
      n++;
    end
    assert (cpt_pulse == '0 && cpt_trigger == '0) else begin
      report_timeout($sformatf("counts were not cleared within %0d cycles", limit));
    end
  endtask

  task automatic settle(input int unsigned n);
    repeat (n) @(negedge clk_n);
  endtask

  // one injection period with an optional trigger response
  task automatic inject(input bit allow_trig, input bit record);
    int unsigned period;
    int unsigned offset;
    bit          with_trig;
    period    = rand_range(20, 40);
    offset    = rand_range(0, 20);
    with_trig = allow_trig && (rand_range(0, 3) != 0);  // about one in four missed
    if (offset > period - 3) offset = period - 3;  // trigger goes high again before next period
    for (int unsigned k = 0; k < period; k++) begin
      @(negedge clk_n);
      ext_pulse = (k < 2);
      trigger   = !(with_trig && k >= offset && k < offset + 2);
      // the change is sampled on the next rising edge
      if (record && k == 0) add_pulse(cyc + 1);
      if (record && with_trig && k == offset) add_trigger(cyc + 1);
    end
  endtask

  task automatic run_scan(input scurve_mode_e mode);
    int unsigned cpt_max;
    int unsigned delay;
    delay   = rand_range(0, 15);
    cpt_max = rand_range(5, 30);
    @(negedge clk_n);
    cfg.mode          = mode;
    cfg.trigger_delay = DELAY_W'(delay);
    cfg.cpt_max       = CNT_W'(cpt_max);
    clear_model();
    @(negedge clk_n);
    test_start = 1'b1;
    wait_cleared(5);
    for (int unsigned i = 0; i < cpt_max; i++) begin
      // in count mode a trigger after the last injection would land after done
      inject(!(mode == MODE_COUNT_EFFI && i == cpt_max - 1), 1'b1);
    end
    wait_done(1'b1, 100);
    saved_pulse = expected_pulses(cpt_max);
    saved_trig  = expected_triggers(mode, delay, cpt_max);
    check_value("cpt_pulse", 32'(cpt_pulse), saved_pulse);
    check_value("cpt_trigger", 32'(cpt_trigger), saved_trig);
  endtask

  task automatic stop_scan();
    @(negedge clk_n);
    test_start = 1'b0;
    wait_done(1'b0, 10);
    settle(40);  // flush the delay line
  endtask

  initial begin
    reset_n       = 1'b0;
    ext_pulse     = 1'b0;
    trigger       = 1'b1;  // idle high
    test_start    = 1'b0;
    cfg           = '0;
    rng           = 65;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_mark = 0;
    saved_pulse   = 0;
    saved_trig    = 0;
    repeat (2) @(negedge clk_n);
    reset_n = 1'b1;

    begin_test();
    @(negedge clk_n);
    check_value("cpt_pulse", 32'(cpt_pulse), 0);
    check_value("cpt_trigger", 32'(cpt_trigger), 0);
    check_value("cpt_done", 32'(cpt_done), 0);
    end_test("reset state");

    begin_test();
    run_scan(MODE_TRIG_EFFI);
    end_test("trigger-efficiency scan");

    // counts freeze once done
    begin_test();
    repeat (5) inject(1'b1, 1'b0);
    settle(30);
    check_value("cpt_pulse", 32'(cpt_pulse), saved_pulse);
    check_value("cpt_trigger", 32'(cpt_trigger), saved_trig);
    check_value("cpt_done", 32'(cpt_done), 1);
    end_test("injections after done");

    begin_test();
    @(negedge clk_n);
    test_start = 1'b0;
    wait_done(1'b0, 10);
    check_value("cpt_pulse", 32'(cpt_pulse), saved_pulse);
    check_value("cpt_trigger", 32'(cpt_trigger), saved_trig);
    repeat (3) inject(1'b1, 1'b0);
    settle(40);
    check_value("cpt_pulse", 32'(cpt_pulse), saved_pulse);
    check_value("cpt_trigger", 32'(cpt_trigger), saved_trig);
    end_test("scan stop");

    begin_test();
    run_scan(MODE_COUNT_EFFI);
    end_test("count-efficiency scan after restart");

    for (int s = 0; s < 4; s++) begin
      stop_scan();
      begin_test();
      if (s % 2 == 0) begin
        run_scan(MODE_TRIG_EFFI);
        end_test("random trigger-efficiency scan");
      end else begin
        run_scan(MODE_COUNT_EFFI);
        end_test("random count-efficiency scan");
      end
    end

    $display("tests run %0d, tests with errors %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
